// ==== src/uart_pkg.sv ====
// uart package
// byte type, wishbone classic request/response structs, register map,
// status layout and the fsm state encodings of receiver and transmitter
package uart_pkg;

	//////////////////////////////////////////////////////////////////////
	// data and register map
	//////////////////////////////////////////////////////////////////////
	typedef logic [7:0] uart_byte_t;      // one serial data byte

	typedef enum logic [1:0] {
		REG_DATA   = 2'd0,                // write sends, read pops
		REG_STATUS = 2'd1                 // rx_full, tx_busy
	} uart_reg_e;

	// wishbone classic, master to slave
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		uart_reg_e  adr;
		uart_byte_t dat;                  // write data
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic       ack;
		uart_byte_t dat;                  // read data, valid with ack
	} wb_rsp_t;

	// STATUS register image
	typedef struct packed {
		logic [5:0] rsvd;                 // reads as zero
		logic       tx_busy;              // bit 1
		logic       rx_full;              // bit 0
	} uart_status_t;

	//////////////////////////////////////////////////////////////////////
	// fsm states
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_BITS, RX_STOP, RX_HOLD} rx_state_e;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_BITS, TX_STOP} tx_state_e;

endpackage

// ==== src/uart_rx.sv ====
// uart receiver
// 8N1 frames, two-flop input synchronizer, start detected on the falling
// edge, each data bit sampled at its midpoint. the finished byte is held
// behind rx_valid/rx_ready until the consumer takes it
`timescale 1ns/1ns

module uart_rx
#(
	parameter int CLK_FRE   = 50,         // clock in MHz
	parameter int BAUD_RATE = 115200
)
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rx_pin,
	output uart_pkg::uart_byte_t rx_data,
	output logic                 rx_valid,
	input  logic                 rx_ready
);
	import uart_pkg::*;

	localparam int          CYCLE    = CLK_FRE * 1000000 / BAUD_RATE;   // clocks per bit
	localparam logic [15:0] BIT_LAST = 16'(CYCLE - 1);
	localparam logic [15:0] BIT_MID  = 16'(CYCLE / 2 - 1);

	rx_state_e   state;
	rx_state_e   next_state;
	logic [1:0]  rx_sync;                 // [1] is the safe copy
	logic        rx_prev;                 // last synchronized level
	logic        rx_fall;                 // start edge
	logic [15:0] cycle_cnt;               // clocks inside the current bit
	logic [2:0]  bit_cnt;                 // data bit index
	logic        bit_end;
	logic        frame_done;              // stop to hold, latch point
	uart_byte_t  rx_bits;                 // shift store

	//////////////////////////////////////////////////////////////////////
	// input sync and edge detect
	//////////////////////////////////////////////////////////////////////
	// reset to idle level so no false start edge comes out of reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_sync <= {rx_sync[0], rx_pin};
			rx_prev <= rx_sync[1];
		end
	end

	assign rx_fall    = rx_prev && !rx_sync[1];
	assign bit_end    = (cycle_cnt == BIT_LAST);
	assign frame_done = (state == RX_STOP) && (next_state == RX_HOLD);

	//////////////////////////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= RX_IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			RX_IDLE:  if (rx_fall) next_state = RX_START;
			RX_START: if (bit_end) next_state = RX_BITS;                  // skip start bit
			RX_BITS:  if (bit_end && bit_cnt == 3'd7) next_state = RX_STOP;
			RX_STOP:  if (cycle_cnt == BIT_MID) next_state = RX_HOLD;      // half stop bit only
			RX_HOLD:  if (rx_ready) next_state = RX_IDLE;                 // byte taken
			default:  next_state = RX_IDLE;
		endcase
	end

	// bit timing, restarts on every state change and every data bit
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cycle_cnt <= '0;
		else if (next_state != state || (state == RX_BITS && bit_end))
			cycle_cnt <= '0;
		else if (state == RX_START || state == RX_BITS || state == RX_STOP)
			cycle_cnt <= cycle_cnt + 16'd1;
		else
			cycle_cnt <= '0;    // idle or holding
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (state != RX_BITS)
			bit_cnt <= '0;
		else if (bit_end)
			bit_cnt <= bit_cnt + 3'd1;
	end

	//////////////////////////////////////////////////////////////////////
	// data path
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (state == RX_BITS && cycle_cnt == BIT_MID)
			rx_bits[bit_cnt] <= rx_sync[1];    // lsb first
		if (frame_done)
			rx_data <= rx_bits;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rx_valid <= 1'b0;
		else if (frame_done)
			rx_valid <= 1'b1;
		else if (rx_valid && rx_ready)
			rx_valid <= 1'b0;                  // handed over
	end

endmodule

// ==== src/uart_tx.sv ====
// uart transmitter
// takes one byte per valid/ready handshake while idle and sends it
// as start bit, 8 data bits lsb first, stop bit. line idles high
`timescale 1ns/1ns

module uart_tx
#(
	parameter int CLK_FRE   = 50,         // clock in MHz
	parameter int BAUD_RATE = 115200
)
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  uart_pkg::uart_byte_t tx_data,
	input  logic                 tx_valid,
	output logic                 tx_ready,
	output logic                 tx_pin
);
	import uart_pkg::*;

	localparam int          CYCLE    = CLK_FRE * 1000000 / BAUD_RATE;
	localparam logic [15:0] BIT_LAST = 16'(CYCLE - 1);

	tx_state_e   state;
	logic [15:0] cycle_cnt;
	logic [2:0]  bit_cnt;
	logic        bit_end;
	logic        take;                    // handshake this cycle
	logic [8:0]  tx_shift;                // stop bit above the data

	assign tx_ready = (state == TX_IDLE);
	assign take     = tx_valid && tx_ready;
	assign bit_end  = (cycle_cnt == BIT_LAST);

	//////////////////////////////////////////////////////////////////////
	// fsm and line driver
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= TX_IDLE;
			cycle_cnt <= '0;
			bit_cnt   <= '0;
			tx_pin    <= 1'b1;        // idle high
		end
		else
		begin
			cycle_cnt <= (state == TX_IDLE || bit_end) ? 16'd0 : cycle_cnt + 16'd1;
			case (state)
				TX_IDLE:
					if (take)
					begin
						tx_pin <= 1'b0;    // start bit
						state  <= TX_START;
					end
				TX_START:
					if (bit_end)
					begin
						tx_pin  <= tx_shift[0];   // bit 0
						bit_cnt <= '0;
						state   <= TX_BITS;
					end
				TX_BITS:
					if (bit_end)
					begin
						tx_pin  <= tx_shift[0];   // next data bit, stop after bit 7
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= TX_STOP;
					end
				TX_STOP:
					if (bit_end)
						state <= TX_IDLE;         // pin already high
				default: state <= TX_IDLE;
			endcase
		end
	end

	// payload shifter
	always_ff @(posedge clk)
	begin
		if (take)
			tx_shift <= {1'b1, tx_data};
		else if (bit_end && (state == TX_START || state == TX_BITS))
			tx_shift <= {1'b1, tx_shift[8:1]};
	end

endmodule

// ==== src/uart_wb_regs.sv ====
// uart register block
// wishbone classic slave with DATA and STATUS. one-cycle ack, receive
// holding register with rx_full, and the byte handoff to the transmitter
`timescale 1ns/1ns

module uart_wb_regs
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  uart_pkg::wb_req_t    wb_req,
	output uart_pkg::wb_rsp_t    wb_rsp,
	input  uart_pkg::uart_byte_t rx_data,
	input  logic                 rx_valid,
	output logic                 rx_ready,
	output uart_pkg::uart_byte_t tx_data,
	output logic                 tx_valid,
	input  logic                 tx_ready,
	input  logic                 tx_state_busy
);
	import uart_pkg::*;

	logic         ack;
	uart_byte_t   rd_dat;                 // read data, returned with ack
	uart_byte_t   rx_hold;                // last received byte
	logic         rx_full;
	logic         tx_busy;
	logic         bus_req;                // new access, acked next clock
	logic         rd_pop;                 // DATA read
	logic         wr_send;                // DATA write
	uart_status_t status;

	assign bus_req  = wb_req.cyc && wb_req.stb && !ack;   // !ack keeps ack one cycle
	assign rd_pop   = bus_req && !wb_req.we && (wb_req.adr == REG_DATA);
	assign wr_send  = bus_req && wb_req.we && (wb_req.adr == REG_DATA);
	// pending byte or frame on the line
	assign tx_busy  = tx_valid || tx_state_busy;
	assign rx_ready = !rx_full;

	always_comb
	begin
		status         = '0;
		status.rx_full = rx_full;
		status.tx_busy = tx_busy;
	end

	//////////////////////////////////////////////////////////////////////
	// bus side
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= bus_req;
	end

	always_ff @(posedge clk)
	begin
		if (bus_req && !wb_req.we)
			case (wb_req.adr)
				REG_DATA:   rd_dat <= rx_hold;
				REG_STATUS: rd_dat <= status;
				default:    rd_dat <= '0;
			endcase
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;

	//////////////////////////////////////////////////////////////////////
	// receive holding register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_full <= 1'b0;
			rx_hold <= '0;        // empty read after reset gives 0
		end
		else
		begin
			if (rd_pop)
				rx_full <= 1'b0;
			if (rx_valid && rx_ready)   // new byte wins over the pop
			begin
				rx_hold <= rx_data;
				rx_full <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// transmit handoff, writes while busy are dropped
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tx_valid <= 1'b0;
		else if (tx_valid && tx_ready)
			tx_valid <= 1'b0;
		else if (wr_send && !tx_busy)
			tx_valid <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (wr_send && !tx_busy)
			tx_data <= wb_req.dat;
	end

endmodule

// ==== src/uart_top.sv ====
// uart peripheral top
// wishbone register block in front of an 8N1 receiver and transmitter,
// baud set by CLK_FRE and BAUD_RATE
`timescale 1ns/1ns

module uart_top
#(
	parameter int CLK_FRE   = 50,         // clock in MHz
	parameter int BAUD_RATE = 115200
)
(
	input  logic              clk,
	input  logic              rst_n,
	input  uart_pkg::wb_req_t wb_req,
	output uart_pkg::wb_rsp_t wb_rsp,
	input  logic              rx_pin,
	output logic              tx_pin
);
	import uart_pkg::*;

	uart_byte_t rx_data;
	logic       rx_valid;
	logic       rx_ready;
	uart_byte_t tx_data;
	logic       tx_valid;
	logic       tx_ready;

	uart_wb_regs uart_wb_regs_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp),
		.rx_data       (rx_data),
		.rx_valid      (rx_valid),
		.rx_ready      (rx_ready),
		.tx_data       (tx_data),
		.tx_valid      (tx_valid),
		.tx_ready      (tx_ready),
		.tx_state_busy (!tx_ready)    // transmitter out of idle
	);

	uart_rx #(.CLK_FRE(CLK_FRE), .BAUD_RATE(BAUD_RATE)) uart_rx_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_pin   (rx_pin),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.rx_ready (rx_ready)
	);

	uart_tx #(.CLK_FRE(CLK_FRE), .BAUD_RATE(BAUD_RATE)) uart_tx_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_data  (tx_data),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_pin   (tx_pin)
	);

endmodule

// ==== testbench/tb_clock_gen.sv ====
// testbench clock and reset source
// free running clk, rst_n held low for RST_CYCLES rising edges
`timescale 1ns/1ns

module tb_clock_gen
#(
	parameter int PERIOD     = 20,        // ns
	parameter int RST_CYCLES = 5
)
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1;                  // released off the edge
	end

endmodule

// ==== testbench/tb_uart_top.sv ====
// uart peripheral testbench
// reads operations from the stim file, runs wishbone cycles and serial
// frames against uart_top, checks read data and status, and guards the
// run with a watchdog. rx_pin is either tx_pin looped back or a frame driver
`timescale 1ns/1ns

module tb_uart_top;
	import uart_pkg::*;

	localparam int    CLK_PERIOD = 20;
	localparam int    CLK_FRE    = 50;         // MHz
	localparam int    BAUD_RATE  = 3125000;
	localparam int    BIT_CLKS   = CLK_FRE * 1000000 / BAUD_RATE;   // 16
	localparam int    ACK_MAX    = 8;          // clocks to wait for ack
	localparam int    POLL_MAX   = 100;        // status reads per poll
	localparam longint MARGIN    = 2000;       // ns on top of the test budget
	localparam string STIM_FILE  = "testbench/uart_stim.txt";

	logic        clk;
	logic        rst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        rx_pin;
	logic        tx_pin;
	logic        drv_line;                      // frame driver output
	logic        loopback;                      // 1: rx_pin follows tx_pin
	logic [15:0] lfsr = 16'd51925;
	int          test_err;                      // errors in the current test
	int          pass_cnt;
	int          fail_cnt;

	// stim columns
	logic [7:0]  op_code[$];
	logic [1:0]  op_adr[$];
	uart_byte_t  op_dat[$];
	uart_byte_t  op_exp[$];

	assign rx_pin = loopback ? tx_pin : drv_line;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(5)) tb_clock_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	uart_top #(.CLK_FRE(CLK_FRE), .BAUD_RATE(BAUD_RATE)) uart_top_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.rx_pin (rx_pin),
		.tx_pin (tx_pin)
	);

	//////////////////////////////////////////////////////////////////////
	// stimulus sources
	//////////////////////////////////////////////////////////////////////
	task automatic load_stim();
		int         fd;
		string      line;
		logic [7:0] c;
		logic [1:0] a;
		uart_byte_t d;
		uart_byte_t e;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("cannot open stimulus file %s", STIM_FILE);
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if ($sscanf(line, "%c %h %h %h", c, a, d, e) == 4)    // comment lines fail here
			begin
				op_code.push_back(c);
				op_adr.push_back(a);
				op_dat.push_back(d);
				op_exp.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic next_random_byte(output uart_byte_t b);
		b = '0;
		repeat (8)
		begin
			lfsr = lfsr_next(lfsr);       // one step per bit
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus and serial drivers, all entered and left at posedge + 2 ns
	//////////////////////////////////////////////////////////////////////
	task automatic bus_cycle(input logic we, input uart_reg_e adr, input uart_byte_t dat,
			output uart_byte_t rdat);
		int n;
		n            = 0;
		rdat         = '0;
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = we;
		wb_req.adr   = adr;
		wb_req.dat   = dat;
		do
		begin
			@(posedge clk);
			#2;
			n++;
		end
		while (!wb_rsp.ack && n < ACK_MAX);
		if (wb_rsp.ack)
		begin
			rdat = wb_rsp.dat;
			if (n != 1)
			begin
				$display("bus ack came %0d clocks after stb instead of 1 at %0t ns",
					n, $time);
				test_err++;
			end
		end
		else
		begin
			$display("bus slave gave no ack within %0d clocks at %0t ns", ACK_MAX, $time);
			test_err++;
		end
		wb_req = '0;
		@(posedge clk);                   // idle clock between cycles
		#2;
		if (wb_rsp.ack !== 1'b0)
		begin
			$display("bus ack stayed high longer than one clock at %0t ns", $time);
			test_err++;
		end
	endtask

	task automatic read_status(output uart_status_t st);
		uart_byte_t r;
		bus_cycle(1'b0, REG_STATUS, '0, r);
		st = uart_status_t'(r);
	endtask

	// waits for a held byte with the transmitter idle
	task automatic poll_status(output uart_status_t st);
		int n;
		n = 0;
		do
		begin
			read_status(st);
			n++;
		end
		while (!(st.rx_full && !st.tx_busy) && n < POLL_MAX);
		if (!(st.rx_full && !st.tx_busy))
		begin
			$display("no byte arrived after %0d status reads at %0t ns", POLL_MAX, $time);
			test_err++;
		end
	endtask

	// start, 8 data bits lsb first, stop
	task automatic send_frame(input uart_byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		repeat (10)
		begin
			drv_line = frame[0];
			frame    = frame >> 1;
			repeat (BIT_CLKS) @(posedge clk);
			#2;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////
	task automatic check_byte(input string what, input uart_byte_t got, input uart_byte_t exp);
		if (got !== exp)
		begin
			$display("ERROR @ %0t ns: %s got %h, expected %h", $time, what, got, exp);
			test_err++;
		end
	endtask

	task automatic check_status(input string what, input uart_status_t got,
			input uart_status_t exp);
		if (got !== exp)
		begin
			$display("ERROR @ %0t ns: %s got rx_full=%b tx_busy=%b (%h), expected %h",
				$time, what, got.rx_full, got.tx_busy, got, exp);
			test_err++;
		end
	endtask

	task automatic run_op(input int i);
		uart_byte_t   r;
		uart_byte_t   rnd;
		uart_status_t st;
		uart_reg_e    adr;
		adr = uart_reg_e'(op_adr[i]);
		case (op_code[i])
			"R":
			begin
				bus_cycle(1'b0, adr, '0, r);
				if (adr == REG_STATUS)
					check_status("STATUS read", uart_status_t'(r), uart_status_t'(op_exp[i]));
				else
					check_byte("DATA read", r, op_exp[i]);
			end
			"W":
			begin
				loopback = 1'b1;
				bus_cycle(1'b1, adr, op_dat[i], r);
				read_status(st);
				check_status("STATUS after write", st, uart_status_t'(op_exp[i]));
			end
			"Q":
			begin
				poll_status(st);
				check_status("STATUS poll", st, uart_status_t'(op_exp[i]));
			end
			"S":
			begin
				loopback = 1'b0;
				send_frame(op_dat[i]);
				read_status(st);
				check_status("STATUS after frame", st, uart_status_t'(op_exp[i]));
			end
			"X":
			begin
				loopback = 1'b0;
				next_random_byte(rnd);
				send_frame(rnd);
				poll_status(st);
				bus_cycle(1'b0, REG_DATA, '0, r);
				check_byte("random frame readback", r, rnd);
				read_status(st);
				check_status("STATUS after readback", st, uart_status_t'(op_exp[i]));
			end
			default:
			begin
				$display("unknown operation %c on stimulus entry %0d", op_code[i], i);
				test_err++;
			end
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		wb_req   = '0;
		drv_line = 1'b1;                  // line idle
		loopback = 1'b1;
		pass_cnt = 0;
		fail_cnt = 0;
		load_stim();
		if (op_code.size() == 0)
		begin
			$display("stimulus file holds no operations");
			fail_cnt++;
		end
		wait (rst_n === 1'b1);
		@(posedge clk);
		#2;
		for (int i = 0; i < op_code.size(); i++)
		begin
			test_err = 0;
			run_op(i);
			$display("test %0d op %c adr %0h dat %h exp %h : %s", i, op_code[i],
				op_adr[i], op_dat[i], op_exp[i], (test_err == 0) ? "ok" : "fail");
			if (test_err == 0)
				pass_cnt++;
			else
				fail_cnt++;
		end
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// budget of 12 bit times per stim entry
	initial
	begin
		longint limit;
		#1;
		limit = longint'(op_code.size()) * 12 * BIT_CLKS * CLK_PERIOD + MARGIN;
		#(limit);
		$display("watchdog: run still going after %0d ns, the DUT looks hung", limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== testbench/uart_stim.txt ====
# op adr dat exp, all hex but op. R read, W write then STATUS read, Q poll STATUS
# until rx_full and tx idle, S frame then STATUS read, X random frame read back
R 1 00 00
R 0 00 00
W 0 5a 02
Q 1 00 01
R 0 00 5a
R 1 00 00
X 0 00 00
X 0 00 00
X 0 00 00
X 0 00 00
S 0 c3 01
S 0 7e 01
R 0 00 c3
R 1 00 01
R 0 00 7e
R 1 00 00
W 0 a5 02
W 0 3c 02
Q 1 00 01
R 0 00 a5
R 1 00 00
R 0 00 a5
R 1 00 00
W 1 ff 00
R 1 00 00

// ==== build.f ====
src/uart_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_wb_regs.sv
src/uart_top.sv
testbench/tb_clock_gen.sv
testbench/tb_uart_top.sv

// ==== Makefile ====
# Verilator build and run of the uart testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
